// ==== hw/l1_dcache_pkg.sv ====
package l1_dcache_pkg;

    localparam logic [15:0] io_region   = 16'hbfaf;     // upper half that selects the device window
    localparam int          line_words  = 4;
    localparam int          line_w      = 32 * line_words;
    localparam int          index_max_w = 12;           // widest set index a field can carry
    localparam int          tag_max_w   = 28;           // wide enough for any index width

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;                             // any bit set makes it a store
        logic        rd;
    } cpu_req_t;

    // same address word, seen by the cache or by the device window
    typedef union packed {
        struct packed {
            logic [21:0] tag;
            logic [5:0]  index;
            logic [1:0]  word;
            logic [1:0]  byte_off;
        } cache;
        struct packed {
            logic [15:0] region;
            logic [15:0] offset;
        } dev;
    } cpu_addr_u;

    typedef struct packed {
        logic              wr;
        logic [31:0]       addr;                        // line aligned
        logic [line_w-1:0] line;
    } mem_req_t;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
    } io_req_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_max_w-1:0] tag;
        logic [line_w-1:0]    line;
    } way_lookup_t;

    typedef struct packed {
        logic [index_max_w-1:0] index;
        logic [4*line_words-1:0] be;
        logic [line_w-1:0]      line;
        logic [tag_max_w-1:0]   tag;
        logic                   set_valid;
        logic                   set_dirty;
        logic                   clr_dirty;
    } way_write_t;

endpackage

// ==== hw/l1_dcache_way.sv ====
`timescale 1ns/1ps

module l1_dcache_way
    import l1_dcache_pkg::*;
#(
    parameter int index_w = 6
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic [index_w-1:0] rd_index,
    input  logic               wr_sel,
    input  way_write_t         wr,
    output way_lookup_t        lookup
);

    localparam int sets  = 1 << index_w;
    localparam int tag_w = 32 - index_w - 4;

    logic [sets-1:0]    valid_q;
    logic [sets-1:0]    dirty_q;
    logic [tag_w-1:0]   tag_mem [sets];
    logic [line_w-1:0]  data_mem [sets];

    logic [index_w-1:0] wr_index;
    logic [tag_w-1:0]   wr_tag;
    logic               fwd;            // write hits the set being read
    logic               valid_new;
    logic               dirty_new;
    logic               valid_rd_q;
    logic               dirty_rd_q;
    logic [tag_w-1:0]   tag_rd_q;
    logic [line_w-1:0]  line_rd_q;

    assign wr_index = wr.index[index_w-1:0];
    assign wr_tag   = wr.tag[tag_w-1:0];
    assign fwd      = wr_sel && (wr_index == rd_index);

    // flag values the written set ends up with
    always_comb
    begin
        valid_new = valid_q[wr_index] | wr.set_valid;
        dirty_new = dirty_q[wr_index];
        if (wr.set_dirty)
            dirty_new = 1'b1;
        else if (wr.clr_dirty)
            dirty_new = 1'b0;
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            valid_q    <= '0;
            dirty_q    <= '0;
            valid_rd_q <= 1'b0;
            dirty_rd_q <= 1'b0;
        end
        else
        begin
            if (wr_sel)
            begin
                valid_q[wr_index] <= valid_new;
                dirty_q[wr_index] <= dirty_new;
            end
            valid_rd_q <= fwd ? valid_new : valid_q[rd_index];
            dirty_rd_q <= fwd ? dirty_new : dirty_q[rd_index];
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_sel)
        begin
            tag_mem[wr_index] <= wr_tag;
            for (int b = 0; b < 4*line_words; b++)
            begin
                if (wr.be[b])
                    data_mem[wr_index][8*b +: 8] <= wr.line[8*b +: 8];
            end
        end
    end

    // synchronous read, new bytes win on a same-set write
    always_ff @(posedge clk)
    begin
        tag_rd_q <= fwd ? wr_tag : tag_mem[rd_index];
        for (int b = 0; b < 4*line_words; b++)
        begin
            if (fwd && wr.be[b])
                line_rd_q[8*b +: 8] <= wr.line[8*b +: 8];
            else
                line_rd_q[8*b +: 8] <= data_mem[rd_index][8*b +: 8];
        end
    end

    assign lookup.valid = valid_rd_q;
    assign lookup.dirty = dirty_rd_q;
    assign lookup.tag   = tag_max_w'(tag_rd_q);
    assign lookup.line  = line_rd_q;

endmodule

// ==== hw/l1_dcache_ctrl.sv ====
`timescale 1ns/1ps

module l1_dcache_ctrl
    import l1_dcache_pkg::*;
#(
    parameter int index_w = 6
)
(
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_valid,
    input  cpu_req_t           cpu_req,
    output logic               cpu_ready,
    output logic               rdata_valid,
    output logic [31:0]        rdata,
    input  way_lookup_t        way0,
    input  way_lookup_t        way1,
    output logic [index_w-1:0] rd_index,
    output way_write_t         wr,
    output logic               wr_sel0,
    output logic               wr_sel1,
    output logic               mem_req,
    output mem_req_t           mem_out,
    input  logic               mem_ack,
    input  logic [line_w-1:0]  mem_rline,
    output logic               io_req,
    output io_req_t            io_out,
    input  logic               io_ack,
    input  logic [31:0]        io_rdata
);

    localparam int sets  = 1 << index_w;
    localparam int tag_w = 32 - index_w - 4;

    typedef enum logic [2:0] {st_idle, st_wb, st_fill, st_refill, st_uncached} state_t;

    state_t             state_q;
    logic               run_q;          // set one edge after reset
    logic               s1_valid;       // lookup stage occupied
    cpu_req_t           s1_req;
    cpu_addr_u          s1_addr;
    logic [index_w-1:0] s1_index;
    logic [tag_w-1:0]   s1_tag;
    logic               s1_store;
    logic               s1_load;
    logic               s1_act;
    logic               s1_io;
    logic               s1_hit;
    logic               s1_miss;
    logic               hit0;
    logic               hit1;
    logic               hit_way;
    logic               in_idle;
    logic               refill;
    logic               accept;
    logic               victim;
    logic               victim_q;
    way_lookup_t        vict_lk;
    logic               start_wb;
    logic               start_fill;
    logic [sets-1:0]    lru_q;          // least recently used way per set
    logic [line_w-1:0]  hit_line;
    logic [31:0]        hit_word;
    logic [15:0]        store_be;
    logic [line_w-1:0]  store_line;
    logic [line_w-1:0]  fill_merge;
    logic [line_w-1:0]  fill_line_q;
    logic [31:0]        fill_word;
    logic               load_done;
    logic [31:0]        load_word;

    assign s1_addr  = s1_req.addr;
    assign s1_index = s1_req.addr[index_w+3:4];
    assign s1_tag   = s1_req.addr[31:index_w+4];
    assign s1_store = |s1_req.wstrb;
    assign s1_load  = s1_req.rd && !s1_store;
    assign s1_act   = s1_valid && (s1_load || s1_store);
    assign s1_io    = s1_addr.dev.region == io_region;

    assign hit0    = way0.valid && (way0.tag[tag_w-1:0] == s1_tag);
    assign hit1    = way1.valid && (way1.tag[tag_w-1:0] == s1_tag);
    assign hit_way = !hit0;
    assign s1_hit  = s1_act && !s1_io && (hit0 || hit1);
    assign s1_miss = s1_act && !s1_io && !(hit0 || hit1);

    assign in_idle = state_q == st_idle;
    assign refill  = state_q == st_refill;

    // only a load hit lets the next request in behind it
    assign cpu_ready = run_q && in_idle && (!s1_act || (s1_load && s1_hit));
    assign accept    = cpu_valid && cpu_ready;
    assign rd_index  = cpu_ready ? cpu_req.addr[index_w+3:4] : s1_index;

    assign hit_line = hit_way ? way1.line : way0.line;
    assign hit_word = hit_line[{s1_addr.cache.word, 5'b00000} +: 32];

    assign store_be   = 16'(s1_req.wstrb) << {s1_addr.cache.word, 2'b00};
    assign store_line = {line_words{s1_req.wdata}};

    // empty way first, else the lru one
    assign victim  = !way0.valid ? 1'b0 : (!way1.valid ? 1'b1 : lru_q[s1_index]);
    assign vict_lk = victim ? way1 : way0;

    assign start_wb   = in_idle && s1_miss && vict_lk.valid && vict_lk.dirty;
    assign start_fill = (in_idle && s1_miss && !(vict_lk.valid && vict_lk.dirty)) ||
                        (state_q == st_wb && !mem_req && !mem_ack);

    always_comb
    begin
        for (int b = 0; b < 4*line_words; b++)
            fill_merge[8*b +: 8] = store_be[b] ? store_line[8*b +: 8] : mem_rline[8*b +: 8];
    end

    assign fill_word = fill_line_q[{s1_addr.cache.word, 5'b00000} +: 32];

    // where a load result comes from in each state
    always_comb
    begin
        load_done = 1'b0;
        load_word = hit_word;
        case (state_q)
            st_idle:
                load_done = s1_hit && s1_load;
            st_refill:
            begin
                load_done = s1_load;
                load_word = fill_word;
            end
            st_uncached:
            begin
                load_done = s1_load && io_req && io_ack;
                load_word = io_rdata;
            end
            default:
                load_done = 1'b0;
        endcase
    end

    assign wr_sel0 = (in_idle && s1_hit && s1_store && !hit_way) || (refill && !victim_q);
    assign wr_sel1 = (in_idle && s1_hit && s1_store && hit_way) || (refill && victim_q);

    assign wr.index     = index_max_w'(s1_index);
    assign wr.tag       = tag_max_w'(s1_tag);
    assign wr.be        = refill ? '1 : store_be;
    assign wr.line      = refill ? fill_line_q : store_line;
    assign wr.set_valid = refill;
    assign wr.set_dirty = s1_store;
    assign wr.clr_dirty = refill && !s1_store;

    assign io_out.wr   = s1_store;
    assign io_out.addr = s1_req.addr;
    assign io_out.data = s1_req.wdata;
    assign io_out.strb = s1_req.wstrb;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state_q     <= st_idle;
            run_q       <= 1'b0;
            s1_valid    <= 1'b0;
            victim_q    <= 1'b0;
            lru_q       <= '0;
            mem_req     <= 1'b0;
            io_req      <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            run_q       <= 1'b1;
            rdata_valid <= load_done;
            case (state_q)
                st_idle:
                begin
                    s1_valid <= accept || s1_miss || (s1_act && s1_io);
                    victim_q <= victim;
                    if (s1_act && s1_io)
                    begin
                        io_req  <= 1'b1;
                        state_q <= st_uncached;
                    end
                    else if (start_wb)
                    begin
                        mem_req <= 1'b1;
                        state_q <= st_wb;
                    end
                    else if (start_fill)
                    begin
                        mem_req <= 1'b1;
                        state_q <= st_fill;
                    end
                    else if (s1_hit)
                        lru_q[s1_index] <= !hit_way;
                end
                st_wb:
                begin
                    if (mem_req && mem_ack)
                        mem_req <= 1'b0;
                    else if (start_fill)            // ack dropped, line read follows
                    begin
                        mem_req <= 1'b1;
                        state_q <= st_fill;
                    end
                end
                st_fill:
                begin
                    if (mem_req && mem_ack)
                        mem_req <= 1'b0;
                    else if (!mem_req && !mem_ack)
                        state_q <= st_refill;
                end
                st_refill:
                begin
                    lru_q[s1_index] <= !victim_q;
                    s1_valid        <= 1'b0;
                    state_q         <= st_idle;
                end
                st_uncached:
                begin
                    if (io_req && io_ack)
                        io_req <= 1'b0;
                    else if (!io_req && !io_ack)
                    begin
                        s1_valid <= 1'b0;
                        state_q  <= st_idle;
                    end
                end
                default:
                    state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            s1_req <= cpu_req;
        if (load_done)
            rdata <= load_word;
        if (state_q == st_fill && mem_req && mem_ack)
            fill_line_q <= fill_merge;          // store bytes land over the fetched line
        if (start_wb)
        begin
            mem_out.wr   <= 1'b1;
            mem_out.addr <= {vict_lk.tag[tag_w-1:0], s1_index, 4'b0000};
            mem_out.line <= vict_lk.line;
        end
        else if (start_fill)
        begin
            mem_out.wr   <= 1'b0;
            mem_out.addr <= {s1_req.addr[31:4], 4'b0000};
            mem_out.line <= '0;
        end
    end

endmodule

// ==== hw/l1_dcache.sv ====
`timescale 1ns/1ps

module l1_dcache
    import l1_dcache_pkg::*;
#(
    parameter int index_w = 6
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cpu_valid,
    input  cpu_req_t          cpu_req,
    output logic              cpu_ready,
    output logic              rdata_valid,
    output logic [31:0]       rdata,
    output logic              mem_req,
    output mem_req_t          mem_out,
    input  logic              mem_ack,
    input  logic [line_w-1:0] mem_rline,
    output logic              io_req,
    output io_req_t           io_out,
    input  logic              io_ack,
    input  logic [31:0]       io_rdata
);

    logic [index_w-1:0] rd_index;       // set read by both ways
    way_write_t         wr;
    logic               wr_sel0;
    logic               wr_sel1;
    way_lookup_t        way0_lookup;
    way_lookup_t        way1_lookup;

    l1_dcache_way #(.index_w(index_w)) way0_inst
    (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .wr_sel   (wr_sel0),
        .wr       (wr),
        .lookup   (way0_lookup)
    );

    l1_dcache_way #(.index_w(index_w)) way1_inst
    (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .wr_sel   (wr_sel1),
        .wr       (wr),
        .lookup   (way1_lookup)
    );

    l1_dcache_ctrl #(.index_w(index_w)) ctrl_inst
    (
        .clk         (clk),
        .rst         (rst),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .cpu_ready   (cpu_ready),
        .rdata_valid (rdata_valid),
        .rdata       (rdata),
        .way0        (way0_lookup),
        .way1        (way1_lookup),
        .rd_index    (rd_index),
        .wr          (wr),
        .wr_sel0     (wr_sel0),
        .wr_sel1     (wr_sel1),
        .mem_req     (mem_req),
        .mem_out     (mem_out),
        .mem_ack     (mem_ack),
        .mem_rline   (mem_rline),
        .io_req      (io_req),
        .io_out      (io_out),
        .io_ack      (io_ack),
        .io_rdata    (io_rdata)
    );

endmodule

// ==== tests/l1_dcache_assert.sv ====
`timescale 1ns/1ps

module l1_dcache_assert
    import l1_dcache_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     mem_req,
    input logic     mem_ack,
    input mem_req_t mem_out,
    input logic     io_req,
    input logic     io_ack,
    input io_req_t  io_out,
    input logic     rdata_valid
);

    // payload held until the acknowledge arrives
    mem_stable: assert property (@(posedge clk) disable iff (!rst)
        (mem_req && !mem_ack) |=> $stable(mem_out))
        else $error("mem_out changed while waiting for mem_ack");

    io_stable: assert property (@(posedge clk) disable iff (!rst)
        (io_req && !io_ack) |=> $stable(io_out))
        else $error("io_out changed while waiting for io_ack");

    one_port: assert property (@(posedge clk) disable iff (!rst) !(mem_req && io_req))
        else $error("mem_req and io_req high together");

    known_valid: assert property (@(posedge clk) disable iff (!rst) !$isunknown(rdata_valid))
        else $error("rdata_valid unknown");

endmodule

bind l1_dcache l1_dcache_assert assert_inst
(
    .clk         (clk),
    .rst         (rst),
    .mem_req     (mem_req),
    .mem_ack     (mem_ack),
    .mem_out     (mem_out),
    .io_req      (io_req),
    .io_ack      (io_ack),
    .io_out      (io_out),
    .rdata_valid (rdata_valid)
);

// ==== tests/l1_dcache_tb.sv ====
`timescale 1ns/1ps

module l1_dcache_tb
    import l1_dcache_pkg::*;
();

    localparam int max_accesses = 400;
    localparam int worst_cycles = 40;     // wb plus fill with slowest acks

    logic              clk;
    logic              rst;
    logic              cpu_valid;
    cpu_req_t          cpu_req;
    logic              cpu_ready;
    logic              rdata_valid;
    logic [31:0]       rdata;
    logic              mem_req;
    mem_req_t          mem_out;
    logic              mem_ack;
    logic [line_w-1:0] mem_rline;
    logic              io_req;
    io_req_t           io_out;
    logic              io_ack;
    logic [31:0]       io_rdata;

    logic [7:0]  mem [65536];
    logic [7:0]  ref_mem [65536];
    logic [31:0] dev_regs [16];
    logic [31:0] dev_ref [16];
    int          mem_reads;
    int          mem_writes;
    int          io_count;
    io_req_t     last_io;
    int          errors;
    int          tests_run;
    int          tests_failed;

    l1_dcache #(.index_w(6)) l1_dcache_inst
    (
        .clk(clk), .rst(rst), .cpu_valid(cpu_valid), .cpu_req(cpu_req),
        .cpu_ready(cpu_ready), .rdata_valid(rdata_valid), .rdata(rdata),
        .mem_req(mem_req), .mem_out(mem_out), .mem_ack(mem_ack), .mem_rline(mem_rline),
        .io_req(io_req), .io_out(io_out), .io_ack(io_ack), .io_rdata(io_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // line memory with a random ack delay
    initial
    begin
        int dly;
        forever
        begin
            @(posedge clk);
            if (mem_req && !mem_ack)
            begin
                dly = $urandom_range(1, 4);
                repeat (dly - 1) @(posedge clk);
                for (int b = 0; b < 16; b++)
                begin
                    if (mem_out.wr)
                        mem[mem_out.addr[15:0] + b] = mem_out.line[8*b +: 8];
                    else
                        mem_rline[8*b +: 8] <= mem[mem_out.addr[15:0] + b];
                end
                if (mem_out.wr)
                    mem_writes++;
                else
                    mem_reads++;
                mem_ack <= 1'b1;
                do @(posedge clk); while (mem_req);
                mem_ack <= 1'b0;
            end
        end
    end

    // device registers on the uncached port
    initial
    begin
        int dly;
        forever
        begin
            @(posedge clk);
            if (io_req && !io_ack)
            begin
                dly = $urandom_range(1, 4);
                repeat (dly - 1) @(posedge clk);
                last_io = io_out;
                io_count++;
                for (int b = 0; b < 4; b++)
                begin
                    if (io_out.wr && io_out.strb[b])
                        dev_regs[io_out.addr[5:2]][8*b +: 8] = io_out.data[8*b +: 8];
                end
                io_rdata <= dev_regs[io_out.addr[5:2]];
                io_ack   <= 1'b1;
                do @(posedge clk); while (io_req);
                io_ack <= 1'b0;
            end
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        if (addr[31:16] == io_region)
            return dev_ref[addr[5:2]];
        return {ref_mem[addr[15:0] + 3], ref_mem[addr[15:0] + 2],
                ref_mem[addr[15:0] + 1], ref_mem[addr[15:0]]};
    endfunction

    // drives one request and checks a load result against the reference
    task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [3:0] strb, output int lat);
        logic [31:0] exp;
        exp = expected_word(addr);
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_req   <= '{addr: addr, wdata: wdata, wstrb: strb, rd: (strb == 4'h0)};
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);
        cpu_valid <= 1'b0;
        lat = 0;
        if (strb == 4'h0)
        begin
            do
            begin
                @(negedge clk);
                lat++;
            end
            while (!rdata_valid);
            if (rdata !== exp)
            begin
                $display("Fail rdata at %h: got %h expected %h", addr, rdata, exp);
                errors++;
            end
        end
        else
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (strb[b] && addr[31:16] == io_region)
                    dev_ref[addr[5:2]][8*b +: 8] = wdata[8*b +: 8];
                else if (strb[b])
                    ref_mem[addr[15:0] + b] = wdata[8*b +: 8];
            end
            @(negedge clk);
            while (!cpu_ready) @(negedge clk);
        end
    endtask

    task automatic check_int(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors != start_errors)
            tests_failed++;
        $display("%s: %s", name, (errors == start_errors) ? "ok" : "errors");
    endtask

    task automatic reset_state_test();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_int("cpu_ready", cpu_ready, 1);
        check_int("rdata_valid", rdata_valid, 0);
        check_int("mem_req", mem_req, 0);
        check_int("io_req", io_req, 0);
        finish_test("reset state", e0);
    endtask

    task automatic miss_then_hit_test();
        int e0;
        int r0;
        int w0;
        int lat;
        e0 = errors;
        r0 = mem_reads;
        w0 = mem_writes;
        access(32'h0000_0100, 0, 4'h0, lat);
        check_int("mem_reads", mem_reads - r0, 1);
        access(32'h0000_0104, 0, 4'h0, lat);
        check_int("mem_reads", mem_reads - r0, 1);
        check_int("mem_writes", mem_writes - w0, 0);
        check_int("hit latency", lat, 2);
        finish_test("load miss and hit", e0);
    endtask

    task automatic partial_store_test();
        int e0;
        int t0;
        int lat;
        e0 = errors;
        t0 = mem_reads + mem_writes + io_count;
        access(32'h0000_0108, 32'h1122_3344, 4'b0011, lat);
        access(32'h0000_010c, 32'haabb_ccdd, 4'b1010, lat);
        access(32'h0000_0108, 32'hffee_0011, 4'b1100, lat);
        access(32'h0000_0108, 0, 4'h0, lat);
        access(32'h0000_010c, 0, 4'h0, lat);
        check_int("bus transfers", mem_reads + mem_writes + io_count - t0, 0);
        finish_test("partial stores", e0);
    endtask

    task automatic replacement_test();
        int e0;
        int w0;
        int lat;
        e0 = errors;
        w0 = mem_writes;
        access(32'h0000_0050, 32'hdead_beef, 4'b1111, lat);    // A dirty
        access(32'h0000_0450, 0, 4'h0, lat);                   // B
        access(32'h0000_0054, 0, 4'h0, lat);                   // A again
        access(32'h0000_0850, 0, 4'h0, lat);                   // C evicts clean B
        check_int("mem_writes", mem_writes - w0, 0);
        access(32'h0000_0c50, 0, 4'h0, lat);                   // D evicts A
        check_int("mem_writes", mem_writes - w0, 1);
        check_int("written back A", {mem[16'h53], mem[16'h52], mem[16'h51], mem[16'h50]},
                  32'hdead_beef);
        access(32'h0000_0050, 0, 4'h0, lat);
        finish_test("replacement", e0);
    endtask

    task automatic device_test();
        int e0;
        int m0;
        int lat;
        e0 = errors;
        m0 = mem_reads + mem_writes;
        access(32'hbfaf_0008, 32'h0bad_cafe, 4'b0110, lat);
        check_int("io_out.addr", last_io.addr, 32'hbfaf_0008);
        check_int("io_out.strb", last_io.strb, 4'b0110);
        check_int("io_out.data", last_io.data, 32'h0bad_cafe);
        check_int("io_out.wr", last_io.wr, 1);
        access(32'hbfaf_0008, 0, 4'h0, lat);
        check_int("io_out.addr", last_io.addr, 32'hbfaf_0008);
        check_int("io_out.wr", last_io.wr, 0);
        check_int("mem transfers", mem_reads + mem_writes - m0, 0);
        finish_test("device region", e0);
    endtask

    task automatic random_test();
        int e0;
        int lat;
        int sets [6];
        logic [31:0] addr;
        logic [3:0]  strb;
        e0 = errors;
        sets = '{2, 3, 7, 9, 5, 16};
        for (int i = 0; i < 200; i++)
        begin
            if ($urandom_range(0, 4) == 0)
                addr = {io_region, 10'h0, 4'($urandom_range(0, 15)), 2'b00};
            else
                addr = {18'h0, 4'($urandom_range(1, 4)), 6'(sets[$urandom_range(0, 3)]),
                        2'($urandom_range(0, 3)), 2'b00};
            strb = $urandom_range(0, 1) ? 4'($urandom_range(1, 15)) : 4'h0;
            access(addr, $urandom, strb, lat);
        end
        foreach (sets[s])
        begin
            access({18'h0, 4'd8, 6'(sets[s]), 4'h0}, 0, 4'h0, lat);
            access({18'h0, 4'd9, 6'(sets[s]), 4'h0}, 0, 4'h0, lat);
        end
        for (int a = 0; a < 65536; a++)
        begin
            if (mem[a] !== ref_mem[a])
            begin
                $display("Fail mem[%h]: got %h expected %h", a, mem[a], ref_mem[a]);
                errors++;
            end
        end
        finish_test("random traffic", e0);
    endtask

    initial
    begin
        #(max_accesses * worst_cycles * 8 + 200);
        $display("timeout, the cache stopped responding");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(42162));
        for (int a = 0; a < 65536; a++)
        begin
            mem[a]     = 8'(a) ^ 8'(a >> 8) ^ 8'h5a;    // pattern over every address bit
            ref_mem[a] = mem[a];
        end
        for (int r = 0; r < 16; r++)
        begin
            dev_regs[r] = 32'h1000_0000 + r;
            dev_ref[r]  = dev_regs[r];
        end
        mem_reads = 0;
        mem_writes = 0;
        io_count = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b0;
        cpu_valid = 1'b0;
        cpu_req = '0;
        mem_ack = 1'b0;
        mem_rline = '0;
        io_ack = 1'b0;
        io_rdata = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        reset_state_test();
        miss_then_hit_test();
        partial_store_test();
        replacement_test();
        device_test();
        random_test();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== l1_dcache.f ====
hw/l1_dcache_pkg.sv
hw/l1_dcache_way.sv
hw/l1_dcache_ctrl.sv
hw/l1_dcache.sv
tests/l1_dcache_assert.sv
tests/l1_dcache_tb.sv

// ==== Makefile ====
# Verilator build and run for the l1_dcache testbench

VERILATOR ?= verilator
TOP       ?= l1_dcache_tb
FILELIST  ?= l1_dcache.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
